/* src/exec_pkg.sv */
/*
  exec package
  opcodes, instruction word and status flags of the execute engine,
  plus register file sizing
*/
`default_nettype none

package exec_pkg;

  ////////////////////
  // register file sizing
  ////////////////////
  localparam int NUM_REG = 8;                // r0 is hardwired to zero
  localparam int REG_W   = 32;               // data width
  localparam int REG_AW  = $clog2(NUM_REG);  // 3 bits for 8 regs

  ////////////////////
  // operations
  ////////////////////
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SLL  = 4'd6,
    OP_SRL  = 4'd7,
    OP_SRA  = 4'd8,
    OP_SLT  = 4'd9,
    OP_SLTU = 4'd10,
    OP_LDI  = 4'd11   // codes above this one are illegal
  } opcode_e;

  // instruction word, msb first
  typedef struct packed {
    opcode_e           opcode;  // [31:28]
    logic [REG_AW-1:0] rd;      // [27:25]
    logic [REG_AW-1:0] rs1;     // [24:22]
    logic [REG_AW-1:0] rs2;     // [21:19]
    logic [2:0]        rsvd;    // [18:16] unused
    logic [15:0]       imm;     // [15:0] zero-extended by LDI
  } instr_t;

  // flags of the last executed instruction
  typedef struct packed {
    logic zero;   // [2] result is 0
    logic neg;    // [1] result msb
    logic carry;  // [0] add carry / sub no-borrow
  } status_t;

endpackage

`default_nettype wire

/* src/axil_pkg.sv */
/*
  AXI4-Lite package
  bus structs, response codes and the host address map
*/
`default_nettype none

package axil_pkg;

  ////////////////////
  // bus sizing and address map
  ////////////////////
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  localparam logic [ADDR_W-1:0] INSTR_ADDR  = 8'h00;  // write-only instruction port
  localparam logic [ADDR_W-1:0] STATUS_ADDR = 8'h04;  // flags in [2:0]
  localparam logic [ADDR_W-1:0] REG_BASE    = 8'h20;  // reg n at base + 4*n

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // master to slave
  typedef struct packed {
    logic                  awvalid;
    logic [ADDR_W-1:0]     awaddr;
    logic                  wvalid;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W/8-1:0]   wstrb;   // taken, not used
    logic                  bready;
    logic                  arvalid;
    logic [ADDR_W-1:0]     araddr;
    logic                  rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    resp_e             bresp;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    resp_e             rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

/* src/reg_file.sv */
/*
  register file
  one write port, NUM_RS combinational read ports, optional zero register
*/
`default_nettype none

module reg_file #(
  parameter int NUM_RS   = 3,  // read port count
  parameter bit ZERO_REG = 1   // r0 reads as zero
) (
  input  wire logic                                      clk_i,
  input  wire logic                                      arst_n_i,   // async, active low
  input  wire logic [exec_pkg::REG_AW-1:0]               rd_addr_i,  // write address
  input  wire logic [exec_pkg::REG_W-1:0]                rd_data_i,  // write data
  input  wire logic                                      rd_en_i,    // write enable
  input  wire logic [NUM_RS-1:0][exec_pkg::REG_AW-1:0]   rs_addr_i,  // read addresses
  output      logic [NUM_RS-1:0][exec_pkg::REG_W-1:0]    rs_data_o   // read data
);

  import exec_pkg::*;

  ////////////////////
  // storage
  ////////////////////
  logic [NUM_REG-1:0]            wr_sel;  // one-hot write decode
  logic [NUM_REG-1:0][REG_W-1:0] regs;

  assign wr_sel = NUM_REG'(rd_en_i) << rd_addr_i;  // all zero when disabled

  for (genvar i = 0; i < NUM_REG; i++) begin : g_reg
    if (ZERO_REG && i == 0) begin : g_zero
      assign regs[i] = '0;  // writes to r0 dropped
    end else begin : g_flop
      always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
          regs[i] <= '0;
        end else if (wr_sel[i]) begin
          regs[i] <= rd_data_i;
        end
      end
    end
  end

  ////////////////////
  // read muxes
  ////////////////////
  for (genvar p = 0; p < NUM_RS; p++) begin : g_rd
    assign rs_data_o[p] = regs[rs_addr_i[p]];  // full mux per port
  end

  ////////////////////
  // checks
  ////////////////////
  a_reg_count : assert property (@(posedge clk_i) NUM_REG <= 64);

  // a write with an x address would corrupt an unknown register
  a_wr_addr_known : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_en_i |-> !$isunknown(rd_addr_i));

endmodule

`default_nettype wire

/* src/alu_arith.sv */
/*
  arithmetic/logic unit
  add, sub and bitwise ops, carry out for add and sub
*/
`default_nettype none

module alu_arith (
  input  wire exec_pkg::opcode_e          op_i,
  input  wire logic [exec_pkg::REG_W-1:0] a_i,      // rs1 operand
  input  wire logic [exec_pkg::REG_W-1:0] b_i,      // rs2 operand
  output      logic [exec_pkg::REG_W-1:0] res_o,
  output      logic                       carry_o   // add carry / sub no-borrow
);

  import exec_pkg::*;

  logic             is_sub;
  logic [REG_W-1:0] b_eff;  // b or ~b
  logic [REG_W:0]   sum;    // extra bit holds the carry

  // one adder for both, sub is a + ~b + 1
  assign is_sub = (op_i == OP_SUB);
  assign b_eff  = is_sub ? ~b_i : b_i;
  assign sum    = {1'b0, a_i} + {1'b0, b_eff} + (REG_W+1)'(is_sub);

  always_comb begin
    res_o   = '0;  // other opcodes
    carry_o = 1'b0;
    case (op_i)
      OP_ADD, OP_SUB: begin
        res_o   = sum[REG_W-1:0];
        carry_o = sum[REG_W];  // 1 on sub means no borrow
      end
      OP_AND: res_o = a_i & b_i;
      OP_OR:  res_o = a_i | b_i;
      OP_XOR: res_o = a_i ^ b_i;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* src/alu_shift.sv */
/*
  shift/compare unit
  logical and arithmetic shifts of a by b[4:0], signed and unsigned set-less-than
*/
`default_nettype none

module alu_shift (
  input  wire exec_pkg::opcode_e          op_i,
  input  wire logic [exec_pkg::REG_W-1:0] a_i,   // value / left operand
  input  wire logic [exec_pkg::REG_W-1:0] b_i,   // shift amount / right operand
  output      logic [exec_pkg::REG_W-1:0] res_o
);

  import exec_pkg::*;

  logic [$clog2(REG_W)-1:0] shamt;  // low 5 bits only
  logic                     lt_s;
  logic                     lt_u;

  assign shamt = b_i[$clog2(REG_W)-1:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    res_o = '0;  // other opcodes
    case (op_i)
      OP_SLL:  res_o = a_i << shamt;
      OP_SRL:  res_o = a_i >> shamt;
      OP_SRA:  res_o = $unsigned($signed(a_i) >>> shamt);  // sign fill
      OP_SLT:  res_o = REG_W'(lt_s);
      OP_SLTU: res_o = REG_W'(lt_u);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* src/result_sel.sv */
/*
  result selector
  picks the unit result or the immediate, flags illegal codes,
  forms status flags and the writeback enable
*/
`default_nettype none

module result_sel (
  input  wire exec_pkg::instr_t           instr_i,
  input  wire logic                       issue_i,    // instruction accepted this cycle
  input  wire logic [exec_pkg::REG_W-1:0] arith_i,
  input  wire logic [exec_pkg::REG_W-1:0] shift_i,
  input  wire logic                       carry_i,    // from alu_arith
  output      logic                       wr_en_o,
  output      logic [exec_pkg::REG_W-1:0] wr_data_o,
  output      exec_pkg::status_t          status_o,   // flags of this result
  output      logic                       illegal_o
);

  import exec_pkg::*;

  logic legal;
  logic use_carry;

  assign legal     = (instr_i.opcode <= OP_LDI);  // 12..15 undefined
  assign illegal_o = !legal;
  assign use_carry = (instr_i.opcode == OP_ADD) || (instr_i.opcode == OP_SUB);

  always_comb begin
    wr_data_o = '0;  // nop and illegal
    case (instr_i.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:     wr_data_o = arith_i;
      OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU:   wr_data_o = shift_i;
      OP_LDI:                                    wr_data_o = REG_W'(instr_i.imm);
      default: ;
    endcase
  end

  // writes to r0 suppressed here as well as in the reg file
  assign wr_en_o = issue_i && legal && (instr_i.opcode != OP_NOP) && (instr_i.rd != '0);

  assign status_o.zero  = (wr_data_o == '0);
  assign status_o.neg   = wr_data_o[REG_W-1];
  assign status_o.carry = use_carry && carry_i;  // only add/sub carry

endmodule

`default_nettype wire

/* src/axil_ctrl.sv */
/*
  AXI4-Lite controller
  write channel issues instructions at INSTR_ADDR, read channel returns
  registers and the latched status; the two channels run independently
*/
`default_nettype none

module axil_ctrl (
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,    // async, active low
  input  wire axil_pkg::axil_req_t         req_i,
  output      axil_pkg::axil_rsp_t         rsp_o,
  output      exec_pkg::instr_t            instr_o,     // decoded wdata
  output      logic                        issue_o,     // execute this cycle
  input  wire logic                        illegal_i,   // opcode undefined
  input  wire exec_pkg::status_t           status_i,    // flags of current result
  output      logic [exec_pkg::REG_AW-1:0] rb_addr_o,   // readback port address
  input  wire logic [axil_pkg::DATA_W-1:0] rb_data_i
);

  import exec_pkg::*;
  import axil_pkg::*;

  typedef enum logic {W_IDLE, W_RESP} w_state_e;
  typedef enum logic {R_IDLE, R_RESP} r_state_e;

  w_state_e          w_state;
  r_state_e          r_state;
  logic              wr_acc;   // aw+w handshake
  logic              rd_acc;   // ar handshake
  logic              aw_hit;
  logic              reg_hit;
  resp_e             bresp_q;
  resp_e             rresp_d;
  resp_e             rresp_q;
  logic [DATA_W-1:0] rdata_d;
  logic [DATA_W-1:0] rdata_q;
  status_t           status_q;

  ////////////////////
  // write channel
  ////////////////////
  assign wr_acc  = (w_state == W_IDLE) && req_i.awvalid && req_i.wvalid;  // both or nothing
  assign aw_hit  = (req_i.awaddr == INSTR_ADDR);
  assign instr_o = instr_t'(req_i.wdata);
  assign issue_o = wr_acc && aw_hit;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_state  <= W_IDLE;
      status_q <= '0;
    end else begin
      case (w_state)
        W_IDLE: if (wr_acc) w_state <= W_RESP;
        W_RESP: if (req_i.bready) w_state <= W_IDLE;
        default: w_state <= W_IDLE;
      endcase
      // nop leaves the flags alone
      if (issue_o && !illegal_i && (instr_o.opcode != OP_NOP)) begin
        status_q <= status_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      bresp_q <= (aw_hit && !illegal_i) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  ////////////////////
  // read channel
  ////////////////////
  assign rd_acc    = (r_state == R_IDLE) && req_i.arvalid;
  assign rb_addr_o = req_i.araddr[REG_AW+1:2];  // word index
  assign reg_hit   = (req_i.araddr[ADDR_W-1:REG_AW+2] == REG_BASE[ADDR_W-1:REG_AW+2])
                     && (req_i.araddr[1:0] == 2'b00);

  always_comb begin
    rdata_d = '0;  // unmapped reads return 0
    rresp_d = RESP_SLVERR;
    if (req_i.araddr == STATUS_ADDR) begin
      rdata_d = DATA_W'(status_q);
      rresp_d = RESP_OKAY;
    end else if (reg_hit) begin
      rdata_d = rb_data_i;
      rresp_d = RESP_OKAY;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_state <= R_IDLE;
    end else begin
      case (r_state)
        R_IDLE: if (rd_acc) r_state <= R_RESP;
        R_RESP: if (req_i.rready) r_state <= R_IDLE;
        default: r_state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      rdata_q <= rdata_d;  // held until rready
      rresp_q <= rresp_d;
    end
  end

  ////////////////////
  // response outputs
  ////////////////////
  assign rsp_o.awready = wr_acc;
  assign rsp_o.wready  = wr_acc;
  assign rsp_o.bvalid  = (w_state == W_RESP);
  assign rsp_o.bresp   = bresp_q;
  assign rsp_o.arready = rd_acc;
  assign rsp_o.rvalid  = (r_state == R_RESP);
  assign rsp_o.rdata   = rdata_q;
  assign rsp_o.rresp   = rresp_q;

  ////////////////////
  // protocol checks
  ////////////////////
  a_bvalid_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_o.bvalid && !req_i.bready |=> rsp_o.bvalid);

  a_rvalid_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_o.rvalid && !req_i.rready |=> rsp_o.rvalid);

  // a second instruction must wait for the pending response
  a_no_issue_in_resp : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    issue_o |-> !rsp_o.bvalid);

endmodule

`default_nettype wire

/* src/exec_top.sv */
/*
  execute engine top
  AXI4-Lite controller, register file, two execution units and result selector
*/
`default_nettype none

module exec_top (
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,    // async, active low
  input  wire axil_pkg::axil_req_t axil_req_i,
  output      axil_pkg::axil_rsp_t axil_rsp_o
);

  import exec_pkg::*;

  instr_t                  instr;
  logic                    issue;
  logic                    illegal;
  status_t                 status_new;   // flags of the current result
  logic [REG_AW-1:0]       rb_addr;
  logic [2:0][REG_W-1:0]   rs_data;      // [0] rs1, [1] rs2, [2] host readback
  logic [REG_W-1:0]        arith_res;
  logic [REG_W-1:0]        shift_res;
  logic                    carry;
  logic                    wr_en;
  logic [REG_W-1:0]        wr_data;

  axil_ctrl u_ctrl (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (axil_req_i),
    .rsp_o     (axil_rsp_o),
    .instr_o   (instr),
    .issue_o   (issue),
    .illegal_i (illegal),
    .status_i  (status_new),
    .rb_addr_o (rb_addr),
    .rb_data_i (rs_data[2])
  );

  reg_file #(
    .NUM_RS   (3),
    .ZERO_REG (1'b1)
  ) u_regs (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rd_addr_i (instr.rd),
    .rd_data_i (wr_data),
    .rd_en_i   (wr_en),
    .rs_addr_i ({rb_addr, instr.rs2, instr.rs1}),
    .rs_data_o (rs_data)
  );

  // both units see the same operands
  alu_arith u_arith (
    .op_i    (instr.opcode),
    .a_i     (rs_data[0]),
    .b_i     (rs_data[1]),
    .res_o   (arith_res),
    .carry_o (carry)
  );

  alu_shift u_shift (
    .op_i  (instr.opcode),
    .a_i   (rs_data[0]),
    .b_i   (rs_data[1]),
    .res_o (shift_res)
  );

  result_sel u_sel (
    .instr_i   (instr),
    .issue_i   (issue),
    .arith_i   (arith_res),
    .shift_i   (shift_res),
    .carry_i   (carry),
    .wr_en_o   (wr_en),
    .wr_data_o (wr_data),
    .status_o  (status_new),
    .illegal_o (illegal)
  );

endmodule

`default_nettype wire

/* bench/exec_tb_tasks.svh */
/*
  AXI4-Lite master tasks and typed compare tasks for the execute engine testbench
  every bus task starts and ends 1 unit after a rising edge
*/
`ifndef EXEC_TB_TASKS_SVH
`define EXEC_TB_TASKS_SVH

  ////////////////////
  // write channel
  ////////////////////
  task automatic offer_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = 4'hf;  // full word only
  endtask

  task automatic wait_write_accept();
    @(negedge clk);
    while (!(rsp.awready && rsp.wready)) @(negedge clk);
    @(posedge clk);  // aw and w taken here
    #1;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
  endtask

  // hold bready low for hold cycles once bvalid shows
  task automatic take_bresp(input int hold, output resp_e resp);
    @(negedge clk);
    while (!rsp.bvalid) @(negedge clk);
    resp = rsp.bresp;
    repeat (hold) begin
      @(negedge clk);
      if (!rsp.bvalid || rsp.bresp !== resp) begin
        $display("ERROR: write response dropped or changed while BREADY was low");
        err_cnt++;
      end
    end
    @(posedge clk);
    #1 req.bready = 1'b1;
    @(posedge clk);  // b handshake
    #1 req.bready = 1'b0;
  endtask

  task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input int hold, output resp_e resp);
    offer_write(addr, data);
    wait_write_accept();
    take_bresp(hold, resp);
  endtask

  ////////////////////
  // read channel
  ////////////////////
  task automatic axil_read(input logic [ADDR_W-1:0] addr, input int hold,
                           output logic [DATA_W-1:0] data, output resp_e resp);
    req.arvalid = 1'b1;
    req.araddr  = addr;
    @(negedge clk);
    while (!rsp.arready) @(negedge clk);
    @(posedge clk);
    #1 req.arvalid = 1'b0;
    @(negedge clk);
    while (!rsp.rvalid) @(negedge clk);
    data = rsp.rdata;
    resp = rsp.rresp;
    repeat (hold) begin  // rready low, response must hold
      @(negedge clk);
      if (!rsp.rvalid || rsp.rdata !== data || rsp.rresp !== resp) begin
        $display("ERROR: read response dropped or changed while RREADY was low");
        err_cnt++;
      end
    end
    @(posedge clk);
    #1 req.rready = 1'b1;
    @(posedge clk);  // r handshake
    #1 req.rready = 1'b0;
  endtask

  ////////////////////
  // compares
  ////////////////////
  task automatic check_data(input string name, input logic [REG_W-1:0] exp,
                            input logic [REG_W-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_resp(input string name, input resp_e exp, input resp_e act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
      err_cnt++;
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected zne %b, actual zne %b", name, exp, act);
      err_cnt++;
    end
  endtask

`endif

/* bench/exec_tb.sv */
/*
  execute engine testbench
  directed tests over AXI4-Lite, checked against a shadow register model
*/
`default_nettype none

module exec_tb;

  import exec_pkg::*;
  import axil_pkg::*;

  localparam int NUM_TESTS   = 5;
  localparam int WDOG_CYCLES = NUM_TESTS * 200;

  logic      clk;
  logic      arst_n;
  axil_req_t req;   // driven 1 unit after the rising edge
  axil_rsp_t rsp;

  logic [REG_W-1:0] shadow_regs [NUM_REG];  // expected register contents
  status_t          shadow_status;          // expected flags
  int               err_cnt;                // failed checks, whole run
  int               pass_cnt;               // tests
  int               fail_cnt;

  exec_top DUT (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .axil_req_i (req),
    .axil_rsp_o (rsp)
  );

  `include "exec_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // reference model
  ////////////////////
  function automatic logic [REG_W-1:0] model_result(input logic [3:0] op,
      input logic [REG_W-1:0] a, input logic [REG_W-1:0] b, input logic [15:0] imm,
      output logic carry);
    logic [REG_W-1:0] res;
    logic [4:0]       sh;
    sh    = b[4:0];  // shift amount, low bits only
    carry = 1'b0;
    res   = '0;
    case (op)
      OP_ADD:  {carry, res} = {1'b0, a} + {1'b0, b};
      OP_SUB: begin
        res   = a - b;
        carry = (a >= b);  // no borrow
      end
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SLL:  res = a << sh;
      OP_SRL:  res = a >> sh;
      OP_SRA:  res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);  // sign fill
      OP_SLT:  res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
      OP_SLTU: res = {31'b0, (a < b)};
      OP_LDI:  res = {16'h0, imm};
      default: res = '0;
    endcase
    return res;
  endfunction

  // fold one bus write into the model, checking its response
  task automatic apply_model(input string name, input logic [REG_W-1:0] word,
                             input resp_e resp);
    instr_t           ins;
    logic [REG_W-1:0] res;
    logic             carry;
    ins = instr_t'(word);
    if (ins.opcode > OP_LDI) begin
      check_resp(name, RESP_SLVERR, resp);  // undefined code, nothing changes
    end else begin
      check_resp(name, RESP_OKAY, resp);
      if (ins.opcode != OP_NOP) begin
        res = model_result(ins.opcode, shadow_regs[ins.rs1], shadow_regs[ins.rs2],
                           ins.imm, carry);
        shadow_status.zero  = (res == '0);
        shadow_status.neg   = res[REG_W-1];
        shadow_status.carry = carry;
        if (ins.rd != 3'd0) begin
          shadow_regs[ins.rd] = res;
        end
      end
    end
  endtask

  task automatic exec_instr(input string name, input logic [3:0] op, input logic [2:0] rd,
                            input logic [2:0] rs1, input logic [2:0] rs2,
                            input logic [15:0] imm, input int hold);
    logic [REG_W-1:0] word;
    resp_e            resp;
    word = {op, rd, rs1, rs2, 3'b000, imm};
    axil_write(INSTR_ADDR, word, hold, resp);
    apply_model(name, word, resp);
  endtask

  task automatic check_reg(input string name, input int n);
    logic [REG_W-1:0] data;
    resp_e            resp;
    axil_read(REG_BASE + 8'(4 * n), 0, data, resp);
    check_resp(name, RESP_OKAY, resp);
    check_data(name, shadow_regs[n], data);
  endtask

  task automatic check_flags(input string name);
    logic [REG_W-1:0] data;
    resp_e            resp;
    axil_read(STATUS_ADDR, 0, data, resp);
    check_resp(name, RESP_OKAY, resp);
    check_data(name, 32'(shadow_status), data);  // upper bits read 0
    check_status(name, shadow_status, status_t'(data[2:0]));
  endtask

  task automatic check_all(input string name);
    for (int n = 0; n < NUM_REG; n++) begin
      check_reg(name, n);
    end
    check_flags(name);
  endtask

  task automatic finish_test(input string name, input int start_err);
    if (err_cnt == start_err) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d check(s) wrong", name, err_cnt - start_err);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic test_reset();
    int start;
    start = err_cnt;
    check_all("reset");
    exec_instr("reset ldi r0", OP_LDI, 3'd0, 3'd0, 3'd0, 16'hbeef, 0);
    check_reg("reset ldi r0", 0);  // r0 stays 0
    check_flags("reset ldi r0");
    finish_test("reset and readback", start);
  endtask

  task automatic test_arith();
    int               start;
    logic [3:0]       op;
    logic [2:0]       rd;
    logic [REG_W-1:0] data;
    resp_e            resp;
    start = err_cnt;
    for (int n = 1; n < NUM_REG; n++) begin
      exec_instr("arith ldi", OP_LDI, 3'(n), 3'd0, 3'd0, 16'($urandom), 0);
    end
    exec_instr("arith neg", OP_SUB, 3'd7, 3'd0, 3'd1, 16'h0, 0);  // r7 = -r1
    exec_instr("arith carry", OP_ADD, 3'd5, 3'd7, 3'd1, 16'h0, 0);  // wraps to 0
    check_reg("arith carry", 5);
    axil_read(STATUS_ADDR, 0, data, resp);
    check_status("arith carry", status_t'(3'b101), status_t'(data[2:0]));
    for (int i = 0; i < 10; i++) begin
      op = 4'(OP_ADD + $urandom_range(4));  // add..xor
      rd = 3'($urandom_range(7, 1));
      exec_instr("arith random", op, rd, 3'($urandom_range(7)), 3'($urandom_range(7)),
                 16'h0, 0);
      check_reg("arith random", int'(rd));
      check_flags("arith random");
    end
    exec_instr("arith sub equal", OP_SUB, 3'd6, 3'd2, 3'd2, 16'h0, 0);
    check_reg("arith sub equal", 6);
    axil_read(STATUS_ADDR, 0, data, resp);
    check_status("arith sub equal", status_t'(3'b101), status_t'(data[2:0]));  // zero, no borrow
    check_all("arith");
    finish_test("load and arithmetic", start);
  endtask

  task automatic test_shift();
    int               start;
    logic [REG_W-1:0] data;
    resp_e            resp;
    start = err_cnt;
    exec_instr("shift ldi", OP_LDI, 3'd1, 3'd0, 3'd0, 16'($urandom) | 16'h0001, 0);
    exec_instr("shift neg", OP_SUB, 3'd2, 3'd0, 3'd1, 16'h0, 0);  // r2 negative
    exec_instr("shift amt", OP_LDI, 3'd3, 3'd0, 3'd0, 16'd0, 0);
    exec_instr("shift amt", OP_LDI, 3'd4, 3'd0, 3'd0, 16'd1, 0);
    exec_instr("shift amt", OP_LDI, 3'd5, 3'd0, 3'd0, 16'd31, 0);
    exec_instr("shift amt", OP_LDI, 3'd6, 3'd0, 3'd0, 16'($urandom), 0);  // upper bits ignored
    for (int k = 0; k < 3; k++) begin
      for (int s = 3; s < 7; s++) begin
        exec_instr("shift", 4'(OP_SLL + k), 3'd7, 3'd2, 3'(s), 16'h0, 0);
        check_reg("shift", 7);
        check_flags("shift");
      end
    end
    exec_instr("shift sra sign", OP_SRA, 3'd7, 3'd2, 3'd5, 16'h0, 0);
    axil_read(REG_BASE + 8'd28, 0, data, resp);
    check_data("shift sra sign", 32'hffff_ffff, data);
    // negative vs positive operand
    exec_instr("slt mixed", OP_SLT, 3'd7, 3'd2, 3'd1, 16'h0, 0);
    axil_read(REG_BASE + 8'd28, 0, data, resp);
    check_data("slt mixed", 32'd1, data);
    exec_instr("sltu mixed", OP_SLTU, 3'd7, 3'd2, 3'd1, 16'h0, 0);
    axil_read(REG_BASE + 8'd28, 0, data, resp);
    check_data("sltu mixed", 32'd0, data);
    check_all("shift");
    finish_test("shift and compare", start);
  endtask

  task automatic test_errors();
    int               start;
    logic [REG_W-1:0] data;
    resp_e            resp;
    start = err_cnt;
    // neg flag set, unlike the flags any rejected write or nop would leave
    exec_instr("err setup", OP_SUB, 3'd2, 3'd0, 3'd1, 16'h0, 0);
    axil_write(8'h24, {4'(OP_LDI), 3'd1, 9'd0, 16'h1234}, 0, resp);  // register address
    check_resp("err write addr", RESP_SLVERR, resp);
    exec_instr("err illegal", 4'hd, 3'd1, 3'd2, 3'd3, 16'h5555, 0);
    axil_read(8'h10, 0, data, resp);
    check_resp("err unmapped read", RESP_SLVERR, resp);
    check_data("err unmapped read", 32'h0, data);
    axil_read(8'h22, 0, data, resp);  // misaligned
    check_resp("err misaligned read", RESP_SLVERR, resp);
    check_data("err misaligned read", 32'h0, data);
    exec_instr("err nop", OP_NOP, 3'd1, 3'd2, 3'd3, 16'h0, 0);
    check_all("errors");
    finish_test("error responses", start);
  endtask

  task automatic test_backpressure();
    int               start;
    int               hold;
    logic [REG_W-1:0] data;
    logic [REG_W-1:0] first;
    logic [REG_W-1:0] second;
    resp_e            resp;
    start = err_cnt;
    exec_instr("bp ldi", OP_LDI, 3'd5, 3'd0, 3'd0, 16'($urandom), $urandom_range(8, 2));
    axil_read(REG_BASE + 8'd20, $urandom_range(8, 2), data, resp);
    check_resp("bp read", RESP_OKAY, resp);
    check_data("bp read", shadow_regs[5], data);
    first  = {4'(OP_LDI), 3'd3, 9'd0, 16'($urandom)};
    second = {4'(OP_ADD), 3'd4, 3'd3, 3'd3, 3'd0, 16'h0};  // uses the first result
    offer_write(INSTR_ADDR, first);
    wait_write_accept();
    offer_write(INSTR_ADDR, second);  // B of the first still pending
    hold = $urandom_range(8, 2);
    repeat (hold) begin
      @(negedge clk);
      if (rsp.awready || rsp.wready) begin
        $display("ERROR: bp: second write accepted while BVALID was pending");
        err_cnt++;
      end
    end
    take_bresp(0, resp);
    apply_model("bp first", first, resp);
    wait_write_accept();
    take_bresp(0, resp);
    apply_model("bp second", second, resp);
    check_all("backpressure");
    finish_test("back-pressure", start);
  endtask

  ////////////////////
  // main sequence and watchdog
  ////////////////////
  initial begin
    void'($urandom(32'haa3b3693));
    req           = '0;
    arst_n        = 1'b0;
    err_cnt       = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    shadow_status = '0;
    foreach (shadow_regs[i]) begin
      shadow_regs[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1 arst_n = 1'b1;
    @(posedge clk);
    #1;
    test_reset();
    test_arith();
    test_shift();
    test_errors();
    test_backpressure();
    $display("tests passed %0d, tests failed %0d, wrong checks %0d",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, a handshake never completed",
             WDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+bench
src/exec_pkg.sv
src/axil_pkg.sv
src/reg_file.sv
src/alu_arith.sv
src/alu_shift.sv
src/result_sel.sv
src/axil_ctrl.sv
src/exec_top.sv
bench/exec_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute engine testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f filelist.f \
  --top-module exec_tb \
  -o exec_sim

./obj_dir/exec_sim | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "run.sh: errors reported in $LOG"
  exit 1
fi
echo "run.sh: no errors reported in $LOG"
